// ==== ibuf_cfg_pkg.sv ====
package ibuf_cfg_pkg;

  // ========================================
  // Fetch line geometry
  // ========================================
  localparam int VADDR_W      = 32;
  localparam int FETCH_W      = 64;
  localparam int PARCEL_W     = 16;
  localparam int LINE_PARCELS = FETCH_W / PARCEL_W;
  localparam int POS_W        = $clog2(LINE_PARCELS);  // Parcel index in a line

  // ========================================
  // Buffer and dispatch group
  // ========================================
  localparam int IBUF_DEPTH = 4;                   // Lines held
  localparam int PTR_W      = $clog2(IBUF_DEPTH);

  localparam int DISP_W = 2;                       // Slots per group
  localparam int CNT_W  = $clog2(DISP_W) + 1;

  // Per-group category limits
  localparam int ALU_DISP_MAX = 2;
  localparam int MEM_DISP_MAX = 1;
  localparam int BRU_DISP_MAX = 1;
  localparam int ILL_DISP_MAX = 1;

endpackage

// ==== rv_inst_pkg.sv ====
package rv_inst_pkg;

  // RV32I major opcodes
  localparam logic [6:0] OPC_LOAD   = 7'b0000011;
  localparam logic [6:0] OPC_STORE  = 7'b0100011;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;
  localparam logic [6:0] OPC_JALR   = 7'b1100111;
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_AUIPC  = 7'b0010111;

  typedef enum logic [1:0] {
    CAT_ALU     = 2'd0,
    CAT_MEM     = 2'd1,
    CAT_BRU     = 2'd2,
    CAT_ILLEGAL = 2'd3
  } inst_cat_e;

  // R-type field layout
  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } rv32_fields_t;

  // Same word as two 16-bit parcels, low parcel first in memory
  typedef struct packed {
    logic [15:0] parcel_hi;
    logic [15:0] parcel_lo;
  } parcel_pair_t;

  typedef union packed {
    rv32_fields_t rv32;
    parcel_pair_t parcels;
  } inst_word_u;

endpackage

// ==== ibuf_line_queue.sv ====
`timescale 1ns/100ps

module ibuf_line_queue
  import ibuf_cfg_pkg::*;
(
  input  logic               i_clk,
  input  logic               i_reset_n,
  input  logic               i_flush,

  input  logic               i_push,
  input  logic [VADDR_W-1:1] i_push_pc,
  input  logic [FETCH_W-1:0] i_push_data,

  input  logic               i_pop,

  output logic               o_not_full,
  output logic               o_head_valid,
  output logic [VADDR_W-1:1] o_head_pc,
  output logic [FETCH_W-1:0] o_head_data,
  output logic               o_next_valid,
  output logic [FETCH_W-1:0] o_next_data
);

  logic [FETCH_W-1:0] r_data [IBUF_DEPTH];
  logic [VADDR_W-1:1] r_pc   [IBUF_DEPTH];

  logic [PTR_W-1:0]   r_inptr;
  logic [PTR_W-1:0]   r_outptr;
  logic [PTR_W:0]     r_count;
  logic [PTR_W-1:0]   w_outptr_p1;

  // ========================================
  // Pointers and occupancy
  // ========================================
  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_inptr  <= '0;
      r_outptr <= '0;
      r_count  <= '0;
    end else if (i_flush) begin
      r_inptr  <= '0;
      r_outptr <= '0;
      r_count  <= '0;
    end else begin
      if (i_push) r_inptr <= r_inptr + 1'b1;
      if (i_pop) r_outptr <= r_outptr + 1'b1;
      case ({i_push, i_pop})
        2'b10:   r_count <= r_count + 1'b1;
        2'b01:   r_count <= r_count - 1'b1;
        default: r_count <= r_count;  // Idle or push with pop
      endcase
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_push) begin
      r_data[r_inptr] <= i_push_data;
      r_pc[r_inptr]   <= i_push_pc;
    end
  end

  assign w_outptr_p1 = r_outptr + 1'b1;

  assign o_not_full   = r_count < (PTR_W+1)'(IBUF_DEPTH);
  assign o_head_valid = r_count != '0;
  assign o_head_pc    = r_pc[r_outptr];
  assign o_head_data  = r_data[r_outptr];
  assign o_next_valid = r_count > (PTR_W+1)'(1);  // Line after head present
  assign o_next_data  = r_data[w_outptr_p1];

  // Push comes from the fetch handshake, pop from the dispatch side
  a_queue_bounds: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    !(i_push && !o_not_full) && !(i_pop && !o_head_valid))
    else $error("line queue push while full or pop while empty");

endmodule

// ==== ibuf_parcel_align.sv ====
`timescale 1ns/100ps

module ibuf_parcel_align
  import ibuf_cfg_pkg::*;
  import rv_inst_pkg::*;
(
  input  logic                           i_clk,
  input  logic                           i_reset_n,
  input  logic                           i_flush,

  input  logic                           i_head_valid,
  input  logic [VADDR_W-1:1]             i_head_pc,
  input  logic [FETCH_W-1:0]             i_head_data,
  input  logic                           i_next_valid,
  input  logic [FETCH_W-1:0]             i_next_data,

  input  logic [DISP_W-1:0]              i_take_mask,
  input  logic                           i_take,

  output logic [DISP_W-1:0]              o_cand_valid,
  output inst_word_u [DISP_W-1:0]        o_cand_inst,
  output logic [DISP_W-1:0]              o_cand_rvc,
  output logic [DISP_W-1:0][VADDR_W-1:0] o_cand_pc,
  output logic                           o_pop
);

  logic [LINE_PARCELS-1:0][PARCEL_W-1:0] w_head_parcels;
  logic [LINE_PARCELS-1:0][PARCEL_W-1:0] w_next_parcels;

  logic               r_first;      // Start offset still comes from head PC
  logic [POS_W-1:0]   r_pos;
  logic [POS_W-1:0]   w_start_pos;
  logic [POS_W:0]     w_adv;        // MSB set means head line consumed
  logic [VADDR_W-1:1] w_line_base;

  assign w_head_parcels = i_head_data;
  assign w_next_parcels = i_next_data;

  assign w_start_pos = r_first ? i_head_pc[POS_W:1] : r_pos;
  assign w_line_base = {i_head_pc[VADDR_W-1:POS_W+1], {POS_W{1'b0}}};

  // ========================================
  // Candidate chain over head and next line
  // ========================================
  always_comb begin
    logic [POS_W:0]      v_idx;
    logic [POS_W:0]      v_idx_hi;
    logic [PARCEL_W-1:0] v_lo;
    logic [PARCEL_W-1:0] v_hi;
    logic                v_lo_ok;
    logic                v_hi_ok;
    logic                v_chain;

    v_idx   = {1'b0, w_start_pos};
    v_chain = 1'b1;
    w_adv   = v_idx;
    for (int k = 0; k < DISP_W; k++) begin
      v_idx_hi = v_idx + 1'b1;
      v_lo     = v_idx[POS_W] ? w_next_parcels[v_idx[POS_W-1:0]] :
                                w_head_parcels[v_idx[POS_W-1:0]];
      v_hi     = v_idx_hi[POS_W] ? w_next_parcels[v_idx_hi[POS_W-1:0]] :
                                   w_head_parcels[v_idx_hi[POS_W-1:0]];
      v_lo_ok  = v_idx[POS_W] ? i_next_valid : i_head_valid;
      v_hi_ok  = v_idx_hi[POS_W] ? i_next_valid : i_head_valid;

      o_cand_rvc[k] = v_lo[1:0] != 2'b11;
      o_cand_inst[k].parcels.parcel_lo = v_lo;
      o_cand_inst[k].parcels.parcel_hi = o_cand_rvc[k] ? '0 : v_hi;
      o_cand_valid[k] = v_chain & v_lo_ok & (o_cand_rvc[k] | v_hi_ok);
      o_cand_pc[k]    = {w_line_base + (VADDR_W-1)'(v_idx), 1'b0};

      v_chain = o_cand_valid[k];
      v_idx   = o_cand_rvc[k] ? v_idx_hi : v_idx + 2'd2;
      if (i_take_mask[k]) w_adv = v_idx;
    end
  end

  assign o_pop = i_take & w_adv[POS_W];

  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_first <= 1'b1;
      r_pos   <= '0;
    end else if (i_flush) begin
      r_first <= 1'b1;
      r_pos   <= '0;
    end else if (i_take) begin
      r_first <= 1'b0;
      r_pos   <= w_adv[POS_W-1:0];  // Carry into the following line
    end
  end

  // Mask is built by the group selector and must be a prefix
  a_take_prefix: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    i_take |-> ((i_take_mask & (i_take_mask + 1'b1)) == '0))
    else $error("take mask not contiguous from slot 0");

endmodule

// ==== ibuf_inst_classify.sv ====
`timescale 1ns/100ps

module ibuf_inst_classify
  import ibuf_cfg_pkg::*;
  import rv_inst_pkg::*;
(
  input  inst_word_u i_inst,
  input  logic       i_rvc,
  output inst_cat_e  o_cat
);

  logic [PARCEL_W-1:0] w_parcel;
  logic [2:0]          w_c_funct3;
  inst_cat_e           w_rv32_cat;
  inst_cat_e           w_rvc_cat;

  assign w_parcel   = i_inst.parcels.parcel_lo;
  assign w_c_funct3 = w_parcel[15:13];

  always_comb begin
    case (i_inst.rv32.opcode)
      OPC_LOAD, OPC_STORE:                    w_rv32_cat = CAT_MEM;
      OPC_BRANCH, OPC_JAL, OPC_JALR:          w_rv32_cat = CAT_BRU;
      OPC_OP, OPC_OP_IMM, OPC_LUI, OPC_AUIPC: w_rv32_cat = CAT_ALU;
      default:                                w_rv32_cat = CAT_ILLEGAL;
    endcase
  end

  // Quadrant and funct3 of the RVC encoding
  always_comb begin
    w_rvc_cat = CAT_ILLEGAL;  // All-zero parcel stays here
    if (w_parcel != '0) begin
      case (w_parcel[1:0])
        2'b00: begin
          case (w_c_funct3)
            3'b010, 3'b110: w_rvc_cat = CAT_MEM;  // c.lw / c.sw
            3'b000:         w_rvc_cat = CAT_ALU;  // c.addi4spn
            default:        w_rvc_cat = CAT_ILLEGAL;
          endcase
        end
        2'b01: begin
          case (w_c_funct3)
            3'b001, 3'b101, 3'b110, 3'b111: w_rvc_cat = CAT_BRU;
            default:                        w_rvc_cat = CAT_ALU;
          endcase
        end
        2'b10: begin
          case (w_c_funct3)
            3'b010, 3'b110: w_rvc_cat = CAT_MEM;  // Stack-relative
            3'b100:         w_rvc_cat = (w_parcel[6:2] == 5'd0) ? CAT_BRU : CAT_ALU;
            default:        w_rvc_cat = CAT_ALU;
          endcase
        end
        default: w_rvc_cat = CAT_ILLEGAL;
      endcase
    end
  end

  assign o_cat = i_rvc ? w_rvc_cat : w_rv32_cat;

endmodule

// ==== ibuf_group_select.sv ====
`timescale 1ns/100ps

module ibuf_group_select
  import ibuf_cfg_pkg::*;
  import rv_inst_pkg::*;
(
  input  logic                   i_flush,
  input  logic [DISP_W-1:0]      i_cand_valid,
  input  inst_cat_e [DISP_W-1:0] i_cand_cat,

  output logic [DISP_W-1:0]      o_take_mask,
  output logic                   o_disp_valid,

  output logic [CNT_W-1:0]       o_alu_cnt,
  output logic [CNT_W-1:0]       o_mem_cnt,
  output logic [CNT_W-1:0]       o_bru_cnt
);

  logic [CNT_W-1:0] w_ill_cnt;

  always_comb begin
    logic v_open;
    logic v_fit;

    v_open      = 1'b1;  // No gap and no branch so far
    o_take_mask = '0;
    o_alu_cnt   = '0;
    o_mem_cnt   = '0;
    o_bru_cnt   = '0;
    w_ill_cnt   = '0;
    for (int k = 0; k < DISP_W; k++) begin
      case (i_cand_cat[k])
        CAT_ALU: v_fit = o_alu_cnt < CNT_W'(ALU_DISP_MAX);
        CAT_MEM: v_fit = o_mem_cnt < CNT_W'(MEM_DISP_MAX);
        CAT_BRU: v_fit = o_bru_cnt < CNT_W'(BRU_DISP_MAX);
        default: v_fit = w_ill_cnt < CNT_W'(ILL_DISP_MAX);
      endcase

      if (v_open & i_cand_valid[k] & v_fit) begin
        o_take_mask[k] = 1'b1;
        case (i_cand_cat[k])
          CAT_ALU: o_alu_cnt = o_alu_cnt + 1'b1;
          CAT_MEM: o_mem_cnt = o_mem_cnt + 1'b1;
          CAT_BRU: o_bru_cnt = o_bru_cnt + 1'b1;
          default: w_ill_cnt = w_ill_cnt + 1'b1;
        endcase
        if (i_cand_cat[k] == CAT_BRU) v_open = 1'b0;  // Group ends after a branch
      end else begin
        v_open = 1'b0;
      end
    end
  end

  assign o_disp_valid = (|o_take_mask) & !i_flush;

endmodule

// ==== inst_buffer.sv ====
`timescale 1ns/100ps

module inst_buffer
  import ibuf_cfg_pkg::*;
  import rv_inst_pkg::*;
(
  input  logic                           i_clk,
  input  logic                           i_reset_n,
  input  logic                           i_flush,

  input  logic                           i_fetch_valid,
  input  logic [VADDR_W-1:1]             i_fetch_pc,
  input  logic [FETCH_W-1:0]             i_fetch_data,
  output logic                           o_fetch_ready,

  output logic                           o_disp_valid,
  output logic [DISP_W-1:0]              o_disp_slot_valid,
  output inst_word_u [DISP_W-1:0]        o_disp_inst,
  output logic [DISP_W-1:0]              o_disp_rvc,
  output logic [DISP_W-1:0][VADDR_W-1:0] o_disp_pc,
  output inst_cat_e [DISP_W-1:0]         o_disp_cat,
  output logic [CNT_W-1:0]               o_disp_alu_cnt,
  output logic [CNT_W-1:0]               o_disp_mem_cnt,
  output logic [CNT_W-1:0]               o_disp_bru_cnt,
  input  logic                           i_disp_ready
);

  logic               w_push;
  logic               w_pop;
  logic               w_take;
  logic [DISP_W-1:0]  w_take_mask;
  logic [DISP_W-1:0]  w_cand_valid;

  logic               w_head_valid;
  logic [VADDR_W-1:1] w_head_pc;
  logic [FETCH_W-1:0] w_head_data;
  logic               w_next_valid;
  logic [FETCH_W-1:0] w_next_data;

  assign w_push            = i_fetch_valid & o_fetch_ready;
  assign w_take            = o_disp_valid & i_disp_ready;
  assign o_disp_slot_valid = w_take_mask;

  ibuf_line_queue u_line_queue (
    .i_clk        (i_clk),
    .i_reset_n    (i_reset_n),
    .i_flush      (i_flush),
    .i_push       (w_push),
    .i_push_pc    (i_fetch_pc),
    .i_push_data  (i_fetch_data),
    .i_pop        (w_pop),
    .o_not_full   (o_fetch_ready),
    .o_head_valid (w_head_valid),
    .o_head_pc    (w_head_pc),
    .o_head_data  (w_head_data),
    .o_next_valid (w_next_valid),
    .o_next_data  (w_next_data)
  );

  ibuf_parcel_align u_parcel_align (
    .i_clk        (i_clk),
    .i_reset_n    (i_reset_n),
    .i_flush      (i_flush),
    .i_head_valid (w_head_valid),
    .i_head_pc    (w_head_pc),
    .i_head_data  (w_head_data),
    .i_next_valid (w_next_valid),
    .i_next_data  (w_next_data),
    .i_take_mask  (w_take_mask),
    .i_take       (w_take),
    .o_cand_valid (w_cand_valid),
    .o_cand_inst  (o_disp_inst),
    .o_cand_rvc   (o_disp_rvc),
    .o_cand_pc    (o_disp_pc),
    .o_pop        (w_pop)
  );

  for (genvar k = 0; k < DISP_W; k++) begin : g_classify
    ibuf_inst_classify u_classify (
      .i_inst (o_disp_inst[k]),
      .i_rvc  (o_disp_rvc[k]),
      .o_cat  (o_disp_cat[k])
    );
  end

  ibuf_group_select u_group_select (
    .i_flush      (i_flush),
    .i_cand_valid (w_cand_valid),
    .i_cand_cat   (o_disp_cat),
    .o_take_mask  (w_take_mask),
    .o_disp_valid (o_disp_valid),
    .o_alu_cnt    (o_disp_alu_cnt),
    .o_mem_cnt    (o_disp_mem_cnt),
    .o_bru_cnt    (o_disp_bru_cnt)
  );

  // Offered slot 0 holds under back-pressure
  a_disp_hold: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    o_disp_valid && !i_disp_ready && !i_flush |=>
      $stable(o_disp_inst[0]) && $stable(o_disp_pc[0]) && o_disp_slot_valid[0])
    else $error("slot 0 changed while stalled");

endmodule

// ==== tb_clk_gen.sv ====
`timescale 1ns/100ps

module tb_clk_gen (
  output logic o_clk,
  output logic o_reset_n
);

  initial o_clk = 1'b0;
  always #5 o_clk = ~o_clk;  // 10 ns period

  initial begin
    o_reset_n = 1'b0;
    repeat (8) @(posedge o_clk);
    @(negedge o_clk);
    o_reset_n = 1'b1;
  end

endmodule

// ==== tb_inst_buffer.sv ====
`timescale 1ns/100ps

module tb_inst_buffer
  import ibuf_cfg_pkg::*;
  import rv_inst_pkg::*;
;

  localparam int N1_LINES    = 24;
  localparam int N2_LINES    = 16;
  localparam int TOTAL_LINES = N1_LINES + N2_LINES;
  localparam int MAX_INST    = TOTAL_LINES * LINE_PARCELS;
  localparam int N_ENC       = 24;
  localparam int STALL_START = 30;  // Ready held low at the start

  // Encodings of every category in full and compressed form
  localparam logic [31:0] ENC_TABLE [N_ENC] = '{
    32'h0000_2083, 32'h0011_2023, 32'h0020_8063, 32'h0000_006f,
    32'h0000_8067, 32'h0020_81b3, 32'h0010_8093, 32'h0000_10b7,
    32'h0000_1097, 32'h0000_007b, 32'h0000_4188, 32'h0000_c188,
    32'h0000_0040, 32'h0000_8000, 32'h0000_0000, 32'h0000_a001,
    32'h0000_c001, 32'h0000_2001, 32'h0000_0505, 32'h0000_4505,
    32'h0000_4082, 32'h0000_c006, 32'h0000_8082, 32'h0000_852e
  };

  logic                           clk;
  logic                           reset_n;
  logic                           i_flush;
  logic                           i_fetch_valid;
  logic [VADDR_W-1:1]             i_fetch_pc;
  logic [FETCH_W-1:0]             i_fetch_data;
  logic                           o_fetch_ready;
  logic                           o_disp_valid;
  logic [DISP_W-1:0]              o_disp_slot_valid;
  inst_word_u [DISP_W-1:0]        o_disp_inst;
  logic [DISP_W-1:0]              o_disp_rvc;
  logic [DISP_W-1:0][VADDR_W-1:0] o_disp_pc;
  inst_cat_e [DISP_W-1:0]         o_disp_cat;
  logic [CNT_W-1:0]               o_disp_alu_cnt;
  logic [CNT_W-1:0]               o_disp_mem_cnt;
  logic [CNT_W-1:0]               o_disp_bru_cnt;
  logic                           i_disp_ready;

  // Stream model
  logic [15:0]        par       [MAX_INST];
  logic [FETCH_W-1:0] line_data [TOTAL_LINES];
  logic [VADDR_W-1:1] line_pc   [TOTAL_LINES];
  logic [31:0]        m_inst    [MAX_INST];
  logic [31:0]        m_pc      [MAX_INST];
  logic               m_rvc     [MAX_INST];
  inst_cat_e          m_cat     [MAX_INST];
  int                 m_end     [MAX_INST];
  int                 n_exp;

  int rd_idx;
  int pushed_lines;
  int stall_pushes;  // Lines accepted since the last take
  int stream_end;
  int fetch_limit;
  int errors;
  int groups;
  int stretch_left;
  logic ready_state;
  logic after_reset;
  logic flush_d;
  logic take;

  logic [DISP_W-1:0]       e_in;
  logic [DISP_W-1:0]       e_present;
  logic [DISP_W-1:0][31:0] e_inst;
  logic [DISP_W-1:0][31:0] e_pc;
  logic [DISP_W-1:0]       e_rvc;
  inst_cat_e [DISP_W-1:0]  e_cat;
  logic [CNT_W-1:0]        e_alu;
  logic [CNT_W-1:0]        e_mem;
  logic [CNT_W-1:0]        e_bru;
  logic [CNT_W-1:0]        e_ill;

  tb_clk_gen u_clk_gen (.o_clk(clk), .o_reset_n(reset_n));

  inst_buffer dut0 (
    .i_clk             (clk),
    .i_reset_n         (reset_n),
    .i_flush           (i_flush),
    .i_fetch_valid     (i_fetch_valid),
    .i_fetch_pc        (i_fetch_pc),
    .i_fetch_data      (i_fetch_data),
    .o_fetch_ready     (o_fetch_ready),
    .o_disp_valid      (o_disp_valid),
    .o_disp_slot_valid (o_disp_slot_valid),
    .o_disp_inst       (o_disp_inst),
    .o_disp_rvc        (o_disp_rvc),
    .o_disp_pc         (o_disp_pc),
    .o_disp_cat        (o_disp_cat),
    .o_disp_alu_cnt    (o_disp_alu_cnt),
    .o_disp_mem_cnt    (o_disp_mem_cnt),
    .o_disp_bru_cnt    (o_disp_bru_cnt),
    .i_disp_ready      (i_disp_ready)
  );

  function automatic inst_cat_e expected_category(input logic [31:0] w, input logic rvc);
    logic [2:0] f3;

    f3 = w[15:13];
    if (!rvc) begin
      if (w[6:0] == OPC_LOAD || w[6:0] == OPC_STORE) return CAT_MEM;
      if (w[6:0] == OPC_BRANCH || w[6:0] == OPC_JAL || w[6:0] == OPC_JALR) return CAT_BRU;
      if (w[6:0] == OPC_OP || w[6:0] == OPC_OP_IMM || w[6:0] == OPC_LUI ||
          w[6:0] == OPC_AUIPC) return CAT_ALU;
      return CAT_ILLEGAL;
    end
    if (w[15:0] == 16'h0000) return CAT_ILLEGAL;
    if (w[1:0] == 2'b00) begin
      if (f3 == 3'b010 || f3 == 3'b110) return CAT_MEM;
      return (f3 == 3'b000) ? CAT_ALU : CAT_ILLEGAL;
    end
    if (w[1:0] == 2'b01) begin
      return (f3 == 3'b001 || f3 == 3'b101 || f3[2:1] == 2'b11) ? CAT_BRU : CAT_ALU;
    end
    if (f3 == 3'b010 || f3 == 3'b110) return CAT_MEM;
    return (f3 == 3'b100 && w[6:2] == 5'd0) ? CAT_BRU : CAT_ALU;
  endfunction

  // Packs a random stream into sequential lines and model entries in order
  task automatic build_stream(input int first_line, input int n_lines, input int start_off,
                              input logic [31:0] base);
    int pos;
    int last;
    logic [31:0] w;
    logic [31:0] rnd;
    logic rvc;

    pos  = first_line * LINE_PARCELS;
    last = (first_line + n_lines) * LINE_PARCELS;
    for (int i = 0; i < start_off; i++) par[pos+i] = 16'h0000;  // Skipped filler
    pos = pos + start_off;
    while (pos < last) begin
      w = ENC_TABLE[$urandom_range(N_ENC-1, 0)];
      if (w[1:0] == 2'b11 && last - pos == 1) w = 32'h0000_0505;  // Last parcel of stream
      rvc = w[1:0] != 2'b11;
      if (!rvc) begin
        rnd = $urandom();
        w[31:7] = rnd[24:0];
      end
      m_rvc[n_exp]  = rvc;
      m_inst[n_exp] = rvc ? {16'h0000, w[15:0]} : w;
      m_pc[n_exp]   = base + 32'((pos - first_line * LINE_PARCELS) * 2);
      m_cat[n_exp]  = expected_category(w, rvc);
      m_end[n_exp]  = pos + (rvc ? 1 : 2);
      par[pos] = w[15:0];
      if (!rvc) par[pos+1] = w[31:16];
      pos   = m_end[n_exp];
      n_exp = n_exp + 1;
    end
    for (int l = first_line; l < first_line + n_lines; l++) begin
      line_data[l] = {par[4*l+3], par[4*l+2], par[4*l+1], par[4*l]};
      line_pc[l]   = base[31:1] + 31'((l - first_line) * LINE_PARCELS);
    end
    line_pc[first_line] = base[31:1] + 31'(start_off);
  endtask

  task automatic drive_cycle(input int cyc);
    if (cyc < STALL_START) begin
      i_disp_ready = 1'b0;
    end else begin
      if (stretch_left == 0) begin
        ready_state  = $urandom_range(3, 0) != 0;
        stretch_left = ready_state ? int'($urandom_range(8, 1)) : int'($urandom_range(12, 1));
      end
      stretch_left = stretch_left - 1;
      i_disp_ready = ready_state;
    end
    i_fetch_valid = pushed_lines < fetch_limit;
    if (pushed_lines < fetch_limit) begin
      i_fetch_pc   = line_pc[pushed_lines];
      i_fetch_data = line_data[pushed_lines];
    end
  endtask

  // ========================================
  // Model state sampled on the rising edge
  // ========================================
  assign take = o_disp_valid & i_disp_ready;

  always_ff @(posedge clk, negedge reset_n) begin
    if (!reset_n) begin
      rd_idx       <= 0;
      pushed_lines <= 0;
      stall_pushes <= 0;
      groups       <= 0;
      after_reset  <= 1'b1;
      flush_d      <= 1'b0;
    end else begin
      after_reset <= 1'b0;
      flush_d     <= i_flush;
      if (i_flush) begin
        rd_idx       <= stream_end;  // New stream follows the old one in the model
        pushed_lines <= N1_LINES;
      end else begin
        if (i_fetch_valid && o_fetch_ready) pushed_lines <= pushed_lines + 1;
        if (take) begin
          rd_idx <= rd_idx + int'(o_disp_slot_valid[0]) + int'(o_disp_slot_valid[1]);
          groups <= groups + 1;
        end
      end
      if (i_flush || take) stall_pushes <= 0;
      else if (i_fetch_valid && o_fetch_ready) stall_pushes <= stall_pushes + 1;
    end
  end

  always_comb begin
    int idx;

    e_alu = '0;
    e_mem = '0;
    e_bru = '0;
    e_ill = '0;
    for (int k = 0; k < DISP_W; k++) begin
      idx          = rd_idx + k;
      e_in[k]      = idx < stream_end;
      e_present[k] = 1'b0;
      e_inst[k]    = '0;
      e_pc[k]      = '0;
      e_rvc[k]     = 1'b0;
      e_cat[k]     = CAT_ALU;
      if (idx < stream_end) begin
        e_present[k] = m_end[idx] <= pushed_lines * LINE_PARCELS;
        e_inst[k]    = m_inst[idx];
        e_pc[k]      = m_pc[idx];
        e_rvc[k]     = m_rvc[idx];
        e_cat[k]     = m_cat[idx];
      end
      if (o_disp_slot_valid[k]) begin
        case (e_cat[k])
          CAT_ALU: e_alu = e_alu + 1'b1;
          CAT_MEM: e_mem = e_mem + 1'b1;
          CAT_BRU: e_bru = e_bru + 1'b1;
          default: e_ill = e_ill + 1'b1;
        endcase
      end
    end
  end

  // ========================================
  // Checks
  // ========================================
  for (genvar k = 0; k < DISP_W; k++) begin : g_slot_chk
    a_in_stream: assert property (@(posedge clk) disable iff (!reset_n)
      take && o_disp_slot_valid[k] |-> e_in[k])
      else begin
        errors++;
        $display("slot %0d dispatched past the end of the stream", k);
      end
    a_inst: assert property (@(posedge clk) disable iff (!reset_n)
      take && o_disp_slot_valid[k] && e_in[k] |-> o_disp_inst[k] == e_inst[k])
      else begin
        errors++;
        $display("ERROR o_disp_inst[%0d] got %h expected %h", k, o_disp_inst[k], e_inst[k]);
      end
    a_pc: assert property (@(posedge clk) disable iff (!reset_n)
      take && o_disp_slot_valid[k] && e_in[k] |-> o_disp_pc[k] == e_pc[k])
      else begin
        errors++;
        $display("ERROR o_disp_pc[%0d] got %h expected %h", k, o_disp_pc[k], e_pc[k]);
      end
    a_rvc: assert property (@(posedge clk) disable iff (!reset_n)
      take && o_disp_slot_valid[k] && e_in[k] |-> o_disp_rvc[k] == e_rvc[k])
      else begin
        errors++;
        $display("ERROR o_disp_rvc[%0d] got %h expected %h", k, o_disp_rvc[k], e_rvc[k]);
      end
    a_cat: assert property (@(posedge clk) disable iff (!reset_n)
      take && o_disp_slot_valid[k] && e_in[k] |-> o_disp_cat[k] == e_cat[k])
      else begin
        errors++;
        $display("ERROR o_disp_cat[%0d] got %h expected %h", k, o_disp_cat[k], e_cat[k]);
      end
    a_hold: assert property (@(posedge clk) disable iff (!reset_n)
      o_disp_valid && !i_disp_ready && !i_flush && o_disp_slot_valid[k] |=>
        o_disp_slot_valid[k] && $stable(o_disp_inst[k]) && $stable(o_disp_pc[k]) &&
        $stable(o_disp_rvc[k]))
      else begin
        errors++;
        $display("offered slot %0d changed while stalled", k);
      end
  end

  a_alu_cnt: assert property (@(posedge clk) disable iff (!reset_n)
    take |-> o_disp_alu_cnt == e_alu)
    else begin
      errors++;
      $display("ERROR o_disp_alu_cnt got %h expected %h", o_disp_alu_cnt, e_alu);
    end
  a_mem_cnt: assert property (@(posedge clk) disable iff (!reset_n)
    take |-> o_disp_mem_cnt == e_mem)
    else begin
      errors++;
      $display("ERROR o_disp_mem_cnt got %h expected %h", o_disp_mem_cnt, e_mem);
    end
  a_bru_cnt: assert property (@(posedge clk) disable iff (!reset_n)
    take |-> o_disp_bru_cnt == e_bru)
    else begin
      errors++;
      $display("ERROR o_disp_bru_cnt got %h expected %h", o_disp_bru_cnt, e_bru);
    end
  a_limits: assert property (@(posedge clk) disable iff (!reset_n)
    take |-> e_alu <= CNT_W'(ALU_DISP_MAX) && e_mem <= CNT_W'(MEM_DISP_MAX) &&
             e_bru <= CNT_W'(BRU_DISP_MAX) && e_ill <= CNT_W'(ILL_DISP_MAX))
    else begin
      errors++;
      $display("group exceeds a category limit");
    end
  a_branch_cut: assert property (@(posedge clk) disable iff (!reset_n)
    take && o_disp_slot_valid[1] |-> e_cat[0] != CAT_BRU)
    else begin
      errors++;
      $display("slot follows a branch in the same group");
    end
  a_slot0: assert property (@(posedge clk) disable iff (!reset_n)
    !i_flush && e_in[0] && e_present[0] |-> o_disp_valid && o_disp_slot_valid[0])
    else begin
      errors++;
      $display("present instruction not offered in slot 0");
    end
  a_slot1: assert property (@(posedge clk) disable iff (!reset_n)
    o_disp_valid && !o_disp_slot_valid[1] |->
      !e_in[1] || !e_present[1] || e_cat[0] == CAT_BRU ||
      (e_cat[0] == e_cat[1] && e_cat[0] != CAT_ALU))
    else begin
      errors++;
      $display("slot 1 left out without a reason");
    end
  a_full: assert property (@(posedge clk) disable iff (!reset_n)
    stall_pushes >= IBUF_DEPTH |-> !o_fetch_ready)
    else begin
      errors++;
      $display("fetch ready high with the buffer full");
    end
  a_reset: assert property (@(posedge clk) disable iff (!reset_n)
    after_reset |-> !o_disp_valid && o_fetch_ready)
    else begin
      errors++;
      $display("wrong dispatch or fetch state after reset");
    end
  a_flush_now: assert property (@(posedge clk) disable iff (!reset_n)
    i_flush |-> !o_disp_valid)
    else begin
      errors++;
      $display("dispatch valid during flush");
    end
  a_after_flush: assert property (@(posedge clk) disable iff (!reset_n)
    flush_d |-> !o_disp_valid && o_fetch_ready)
    else begin
      errors++;
      $display("wrong dispatch or fetch state after flush");
    end

  // ========================================
  // Stimulus
  // ========================================
  initial begin
    int cyc;

    i_flush       = 1'b0;
    i_fetch_valid = 1'b0;
    i_fetch_pc    = '0;
    i_fetch_data  = '0;
    i_disp_ready  = 1'b0;
    errors        = 0;
    n_exp         = 0;
    stretch_left  = 0;
    ready_state   = 1'b0;
    stream_end    = 0;
    fetch_limit   = 0;
    cyc           = 0;
    void'($urandom(32'h8028_ad1c));
    build_stream(0, N1_LINES, 0, 32'h0000_1000);
    stream_end = n_exp;
    build_stream(N1_LINES, N2_LINES, 1, 32'h0000_8000);  // Starts at parcel 1
    fetch_limit = N1_LINES;

    @(posedge reset_n);
    do begin
      @(negedge clk);
      drive_cycle(cyc);
      cyc++;
    end while (rd_idx < stream_end / 2 || !o_disp_valid);

    // Flush mid-stream while a group is on offer
    i_flush       = 1'b1;
    i_fetch_valid = 1'b0;
    i_disp_ready  = 1'b0;
    @(negedge clk);
    i_flush     = 1'b0;
    stream_end  = n_exp;
    fetch_limit = TOTAL_LINES;
    do begin
      @(negedge clk);
      drive_cycle(cyc);
      cyc++;
    end while (rd_idx < stream_end);

    repeat (3) @(negedge clk);
    $display("errors=%0d groups=%0d", errors, groups);
    if (errors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

  // Watchdog of 40 cycles per line
  initial begin
    repeat (40 * TOTAL_LINES) @(posedge clk);
    $display("watchdog expired before the stream was dispatched, errors=%0d", errors);
    $display("SIMULATION FAILED");
    $finish;
  end

endmodule

// ==== verilog.f ====
ibuf_cfg_pkg.sv
rv_inst_pkg.sv
ibuf_line_queue.sv
ibuf_parcel_align.sv
ibuf_inst_classify.sv
ibuf_group_select.sv
inst_buffer.sv
tb_clk_gen.sv
tb_inst_buffer.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_inst_buffer
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)

test: $(BUILD_DIR)/V$(TOP)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^SIMULATION PASSED$$"

clean:
	rm -rf $(BUILD_DIR)
